//--- mmio_stimulus.txt
# op addr wdata expect, all in hex
# W write, R read, T mtime read checked against the counter, C mtimecmp port equals {wdata, expect}
W 00000000 11111111 00000000
W 00000004 22222222 00000000
W 00000ffc cafef00d 00000000
R 00000000 00000000 11111111
R 00000004 00000000 22222222
R 00000ffc 00000000 cafef00d
R 00001ffc 00000000 cafef00d
W 00001100 aaaa5555 00000000
R 00000100 00000000 aaaa5555
W 00001028 deadbeef 00000000
W 0000102c 12345678 00000000
R 00001028 00000000 deadbeef
R 0000102c 00000000 12345678
C 00000000 12345678 deadbeef
T 00001020 00000000 00000000
W 00001000 00000011 00000000
W 00001000 00000022 00000000
W 00001000 00000033 00000000
R 00001000 00000000 00000003
R 00001010 00000000 00000133
W 00001000 0000005a 00000000
R 00001010 00000000 0000015a
R 00001010 00000000 0000005a
W 00001000 000000c3 00000000
R 00000004 00000000 22222222
R 00001000 00000000 00000005
R 00000000 00000000 11111111

//--- compile.f
mmio_pkg.sv
mem_map_ctrl.sv
data_memory.sv
mmio_uart_tx.sv
mmio_uart_rx.sv
mmio_mtime_reg.sv
mmio_subsys.sv
mmio_props.sv
mmio_checker.sv
tb_mmio_subsys.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f compile.f --top-module tb_mmio_subsys -o sim_mmio

./obj_dir/sim_mmio | tee sim.log

# the run counts as passed only if the log holds the pass line
grep -qx "Test passed" sim.log

//--- tb_mmio_subsys.sv
`timescale 1ns/1ps

module tb_mmio_subsys;

    localparam int              fill_words     = 8;
    localparam mmio_pkg::addr_t fill_base      = 32'h0000_0400;
    localparam int              cycles_per_cmd = 10 * mmio_pkg::clks_per_bit + 20;

    logic             clk;
    logic             rst_n;
    logic             serial_line;
    mmio_pkg::mtime_t mtime_cnt = '0;
    logic             cmd_start;
    logic             write;
    mmio_pkg::addr_t  addr;
    mmio_pkg::word_t  wdata;
    mmio_pkg::mtime_t mtimecmp;
    logic             cmd_ready;
    mmio_pkg::word_t  rdata;
    logic             rdata_valid;
    logic             exp_push;
    logic             exp_range;
    mmio_pkg::word_t  exp_value;
    logic             cmp_check;
    mmio_pkg::mtime_t cmp_value;
    int               error_count;
    int               check_count;
    int               pending;
    int               tb_errors;
    bit               loaded;
    bit               finished;

    logic [7:0]       stim_op [$];
    mmio_pkg::addr_t  stim_addr [$];
    mmio_pkg::word_t  stim_wdata [$];
    mmio_pkg::word_t  stim_expect [$];

    // serial loopback from transmitter to receiver
    mmio_subsys u_mmio_subsys (
        .clk         (clk),
        .rst_n       (rst_n),
        .uart_rx     (serial_line),
        .mtime       (mtime_cnt),
        .cmd_start   (cmd_start),
        .write       (write),
        .addr        (addr),
        .wdata       (wdata),
        .uart_tx     (serial_line),
        .mtimecmp    (mtimecmp),
        .cmd_ready   (cmd_ready),
        .rdata       (rdata),
        .rdata_valid (rdata_valid)
    );

    mmio_checker u_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_start   (cmd_start),
        .write       (write),
        .cmd_ready   (cmd_ready),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .mtimecmp    (mtimecmp),
        .exp_push    (exp_push),
        .exp_range   (exp_range),
        .exp_value   (exp_value),
        .cmp_check   (cmp_check),
        .cmp_value   (cmp_value),
        .error_count (error_count),
        .check_count (check_count),
        .pending     (pending)
    );

    always #5 clk = ~clk;

    always @(negedge clk)
        mtime_cnt <= mtime_cnt + 1'b1;

    task automatic load_stimulus();
        int              fd;
        int              n;
        string           line;
        mmio_pkg::addr_t a;
        mmio_pkg::word_t d;
        mmio_pkg::word_t e;
        fd = $fopen("mmio_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open mmio_stimulus.txt");
            tb_errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // skip comments and empty lines
            if (line.len() < 2 || line.getc(0) == "#")
                continue;
            n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, d, e);
            if (n != 3) begin
                $display("malformed stimulus line: %s", line);
                tb_errors++;
                continue;
            end
            stim_op.push_back(line.getc(0));
            stim_addr.push_back(a);
            stim_wdata.push_back(d);
            stim_expect.push_back(e);
        end
        $fclose(fd);
    endtask

    // called on a falling edge, holds cmd_start until the DUT takes it
    task automatic send_command(input logic wr, input mmio_pkg::addr_t a,
                                input mmio_pkg::word_t d);
        cmd_start = 1'b1;
        write     = wr;
        addr      = a;
        wdata     = d;
        while (!cmd_ready)
            @(negedge clk);
        @(negedge clk);
        cmd_start = 1'b0;
        write     = 1'b0;
    endtask

    task automatic read_and_expect(input mmio_pkg::addr_t a, input logic ranged,
                                   input mmio_pkg::word_t value);
        exp_push  = 1'b1;
        exp_range = ranged;
        exp_value = value;
        @(negedge clk);
        exp_push = 1'b0;
        send_command(1'b0, a, '0);
    endtask

    task automatic check_mtimecmp(input mmio_pkg::mtime_t value);
        cmp_check = 1'b1;
        cmp_value = value;
        @(negedge clk);
        cmp_check = 1'b0;
    endtask

    // random words written and read back
    task automatic fill_memory();
        mmio_pkg::word_t data [fill_words];
        for (int i = 0; i < fill_words; i++) begin
            data[i] = $urandom();
            send_command(1'b1, fill_base + mmio_pkg::addr_t'(4 * i), data[i]);
        end
        for (int i = 0; i < fill_words; i++)
            read_and_expect(fill_base + mmio_pkg::addr_t'(4 * i), 1'b0, data[i]);
    endtask

    task automatic run_stimulus();
        for (int i = 0; i < stim_op.size(); i++) begin
            case (stim_op[i])
                "W": send_command(1'b1, stim_addr[i], stim_wdata[i]);
                "R": read_and_expect(stim_addr[i], 1'b0, stim_expect[i]);
                "T": read_and_expect(stim_addr[i], 1'b1, '0);
                "C": check_mtimecmp({stim_wdata[i], stim_expect[i]});
                default: begin
                    $display("unknown operation in stimulus entry %0d", i + 1);
                    tb_errors++;
                end
            endcase
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        cmd_start = 1'b0;
        write     = 1'b0;
        addr      = '0;
        wdata     = '0;
        exp_push  = 1'b0;
        exp_range = 1'b0;
        exp_value = '0;
        cmp_check = 1'b0;
        cmp_value = '0;
        tb_errors = 0;
        finished  = 1'b0;
        void'($urandom(32'h6172449d));
        load_stimulus();
        loaded = 1'b1;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        fill_memory();
        run_stimulus();
        // let the last responses drain
        while (pending != 0)
            @(negedge clk);
        @(negedge clk);
        $display("checks %0d, errors %0d", check_count, error_count + tb_errors);
        finished = 1'b1;
        if (error_count + tb_errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

    initial begin
        int limit;
        wait (loaded);
        limit = (stim_op.size() + 2 * fill_words) * cycles_per_cmd + 2 * 16;
        repeat (limit) @(posedge clk);
        $display("timeout after %0d cycles, the command sequence never completed", limit);
        finished = 1'b1;
        $display("Test failed");
        $finish;
    end

    // run ended some other way, e.g. by an assertion
    final begin
        if (!finished)
            $display("Test failed");
    end

endmodule

//--- mmio_checker.sv
`timescale 1ns/1ps

module mmio_checker (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cmd_start,
    input  logic             write,
    input  logic             cmd_ready,
    input  mmio_pkg::word_t  rdata,
    input  logic             rdata_valid,
    input  mmio_pkg::mtime_t mtimecmp,
    input  logic             exp_push,
    input  logic             exp_range,
    input  mmio_pkg::word_t  exp_value,
    input  logic             cmp_check,
    input  mmio_pkg::mtime_t cmp_value,
    output int               error_count,
    output int               check_count,
    output int               pending
);

    // own copy of the mtime counter, one step per falling edge
    mmio_pkg::mtime_t ref_time = '0;
    mmio_pkg::word_t  exp_q [$];
    logic             range_q [$];
    mmio_pkg::mtime_t accept_q [$];
    int               errors = 0;
    int               checks = 0;

    assign error_count = errors;
    assign check_count = checks;

    always @(negedge clk)
        ref_time <= ref_time + 1'b1;

    always @(posedge clk) begin
        mmio_pkg::word_t  expected;
        logic             ranged;
        mmio_pkg::mtime_t t_acc;
        if (rdata_valid) begin
            if (exp_q.size() == 0 || accept_q.size() == 0) begin
                $display("rdata_valid pulsed with no read outstanding");
                errors++;
            end else begin
                expected = exp_q.pop_front();
                ranged   = range_q.pop_front();
                t_acc    = accept_q.pop_front();
                checks++;
                // mtime may have moved by one between acceptance and capture
                if (ranged && (rdata < t_acc[31:0] || rdata > t_acc[31:0] + 32'd1)) begin
                    $display("Fail rdata: got %h expected %h to %h",
                             rdata, t_acc[31:0], t_acc[31:0] + 32'd1);
                    errors++;
                end else if (!ranged && rdata !== expected) begin
                    $display("Fail rdata: got %h expected %h", rdata, expected);
                    errors++;
                end
            end
        end
        if (rst_n && cmd_start && cmd_ready && !write)
            accept_q.push_back(ref_time);
        if (exp_push) begin
            exp_q.push_back(exp_value);
            range_q.push_back(exp_range);
        end
        if (cmp_check) begin
            checks++;
            if (mtimecmp !== cmp_value) begin
                $display("Fail mtimecmp: got %h expected %h", mtimecmp, cmp_value);
                errors++;
            end
        end
        pending <= exp_q.size();
    end

endmodule

//--- mmio_props.sv
`timescale 1ns/1ps

module mmio_props (
    input logic              clk,
    input logic              rst_n,
    input logic              cmd_start,
    input logic              write,
    input mmio_pkg::addr_t   addr,
    input logic              cmd_ready,
    input logic              rdata_valid,
    input logic              mem_start,
    input logic              uart_tx_start,
    input logic              uart_rx_start,
    input logic              mtime_start,
    input mmio_pkg::target_e saved_tgt
);

    mmio_pkg::addr_t   window_addr;
    mmio_pkg::target_e addr_tgt;
    logic [3:0]        start_vec;
    logic [3:0]        expect_vec;

    // windows are aligned, so clearing the offset bits leaves the base
    assign window_addr = addr & ~(mmio_pkg::periph_span - 1'b1);

    always_comb begin
        if (window_addr == mmio_pkg::uart_tx_base)
            addr_tgt = mmio_pkg::tgt_uart_tx;
        else if (window_addr == mmio_pkg::uart_rx_base)
            addr_tgt = mmio_pkg::tgt_uart_rx;
        else if (window_addr == mmio_pkg::mtime_base)
            addr_tgt = mmio_pkg::tgt_mtime;
        else
            addr_tgt = mmio_pkg::tgt_mem;
    end

    assign start_vec  = {mtime_start, uart_rx_start, uart_tx_start, mem_start};
    assign expect_vec = (cmd_start && cmd_ready) ? 4'b0001 << addr_tgt : 4'b0000;

    // every target answers a read one cycle after acceptance
    valid_follows_read: assert property (@(posedge clk) disable iff (!rst_n)
        rdata_valid |-> $past(cmd_start && cmd_ready && !write))
        else $error("rdata_valid without an accepted read");

    single_start: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(start_vec) && start_vec == expect_vec)
        else $error("start did not reach exactly the addressed target");

    ready_after_reset: assert property (@(posedge clk)
        (!$past(rst_n) && rst_n) |-> cmd_ready)
        else $error("cmd_ready low on the first cycle after reset");

    target_saved: assert property (@(posedge clk) disable iff (!rst_n)
        (cmd_start && cmd_ready) |=> (saved_tgt == $past(addr_tgt)))
        else $error("saved target does not match the accepted command");

endmodule

bind mem_map_ctrl mmio_props u_props (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd_start     (cmd_start),
    .write         (write),
    .addr          (addr),
    .cmd_ready     (cmd_ready),
    .rdata_valid   (rdata_valid),
    .mem_start     (mem_start),
    .uart_tx_start (uart_tx_start),
    .uart_rx_start (uart_rx_start),
    .mtime_start   (mtime_start),
    .saved_tgt     (saved_tgt)
);

//--- mmio_subsys.sv
`timescale 1ns/1ps

module mmio_subsys (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             uart_rx,
    input  mmio_pkg::mtime_t mtime,
    input  logic             cmd_start,
    input  logic             write,
    input  mmio_pkg::addr_t  addr,
    input  mmio_pkg::word_t  wdata,
    output logic             uart_tx,
    output mmio_pkg::mtime_t mtimecmp,
    output logic             cmd_ready,
    output mmio_pkg::word_t  rdata,
    output logic             rdata_valid
);

    logic            mem_start, mem_write, mem_ready, mem_rdata_valid;
    mmio_pkg::addr_t mem_addr;
    mmio_pkg::word_t mem_wdata, mem_rdata;

    logic            uart_tx_start, uart_tx_write, uart_tx_ready, uart_tx_rdata_valid;
    mmio_pkg::addr_t uart_tx_offset;
    mmio_pkg::word_t uart_tx_wdata, uart_tx_rdata;

    logic            uart_rx_start, uart_rx_write, uart_rx_ready, uart_rx_rdata_valid;
    mmio_pkg::addr_t uart_rx_offset;
    mmio_pkg::word_t uart_rx_rdata;

    logic            mtime_start, mtime_write, mtime_ready, mtime_rdata_valid;
    mmio_pkg::addr_t mtime_offset;
    mmio_pkg::word_t mtime_wdata, mtime_rdata;

    // receiver has no writable register
    mem_map_ctrl u_ctrl (
        .*,
        .uart_rx_wdata ()
    );

    data_memory u_mem (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_start   (mem_start),
        .write       (mem_write),
        .addr        (mem_addr),
        .wdata       (mem_wdata),
        .cmd_ready   (mem_ready),
        .rdata       (mem_rdata),
        .rdata_valid (mem_rdata_valid)
    );

    mmio_uart_tx u_uart_tx (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_start   (uart_tx_start),
        .write       (uart_tx_write),
        .offset      (uart_tx_offset),
        .wdata       (uart_tx_wdata),
        .cmd_ready   (uart_tx_ready),
        .rdata       (uart_tx_rdata),
        .rdata_valid (uart_tx_rdata_valid),
        .uart_tx     (uart_tx)
    );

    mmio_uart_rx u_uart_rx (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_start   (uart_rx_start),
        .write       (uart_rx_write),
        .offset      (uart_rx_offset),
        .uart_rx     (uart_rx),
        .cmd_ready   (uart_rx_ready),
        .rdata       (uart_rx_rdata),
        .rdata_valid (uart_rx_rdata_valid)
    );

    mmio_mtime_reg u_mtime (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_start   (mtime_start),
        .write       (mtime_write),
        .offset      (mtime_offset),
        .wdata       (mtime_wdata),
        .mtime       (mtime),
        .cmd_ready   (mtime_ready),
        .rdata       (mtime_rdata),
        .rdata_valid (mtime_rdata_valid),
        .mtimecmp    (mtimecmp)
    );

endmodule

//--- mmio_mtime_reg.sv
`timescale 1ns/1ps

module mmio_mtime_reg (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cmd_start,
    input  logic             write,
    input  mmio_pkg::addr_t  offset,
    input  mmio_pkg::word_t  wdata,
    input  mmio_pkg::mtime_t mtime,
    output logic             cmd_ready,
    output mmio_pkg::word_t  rdata,
    output logic             rdata_valid,
    output mmio_pkg::mtime_t mtimecmp
);

    mmio_pkg::word_t read_word;

    assign cmd_ready = 1'b1;

    // 0 and 4 mtime, 8 and 12 mtimecmp
    always_comb begin
        case (offset[3:2])
            2'd0:    read_word = mtime[31:0];
            2'd1:    read_word = mtime[63:32];
            2'd2:    read_word = mtimecmp[31:0];
            default: read_word = mtimecmp[63:32];
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // all ones keeps the timer from matching
            mtimecmp    <= '1;
            rdata_valid <= 1'b0;
        end else begin
            rdata_valid <= cmd_start && !write;
            if (cmd_start && write) begin
                if (offset[3:2] == 2'd2)
                    mtimecmp[31:0] <= wdata;
                else if (offset[3:2] == 2'd3)
                    mtimecmp[63:32] <= wdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_start && !write)
            rdata <= read_word;
    end

endmodule

//--- mmio_uart_rx.sv
`timescale 1ns/1ps

module mmio_uart_rx (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            cmd_start,
    input  logic            write,
    input  mmio_pkg::addr_t offset,
    input  logic            uart_rx,
    output logic            cmd_ready,
    output mmio_pkg::word_t rdata,
    output logic            rdata_valid
);

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } uart_rx_state_e;

    uart_rx_state_e                 state;
    logic                           rx_meta;
    logic                           rx_sync;
    logic [mmio_pkg::baud_bits-1:0] baud_cnt;
    logic [2:0]                     bit_idx;
    mmio_pkg::byte_t                shift_reg;
    mmio_pkg::byte_t                rx_byte;
    logic                           rx_valid;
    logic                           bit_done;
    logic                           half_done;

    assign bit_done  = int'(baud_cnt) == mmio_pkg::clks_per_bit - 1;
    assign half_done = int'(baud_cnt) == mmio_pkg::clks_per_bit / 2 - 1;
    assign cmd_ready = 1'b1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta     <= 1'b1;
            rx_sync     <= 1'b1;
            state       <= rx_idle;
            baud_cnt    <= '0;
            bit_idx     <= '0;
            rx_valid    <= 1'b0;
            rdata_valid <= 1'b0;
        end else begin
            rx_meta     <= uart_rx;
            rx_sync     <= rx_meta;
            rdata_valid <= cmd_start && !write;
            baud_cnt    <= bit_done ? '0 : baud_cnt + 1'b1;

            if (cmd_start && !write) begin
                rdata <= {23'h0, rx_valid, rx_byte};
                // offset 0 pops the byte, other offsets only peek
                if (offset[3:2] == 2'b00)
                    rx_valid <= 1'b0;
            end

            case (state)
                rx_idle: begin
                    baud_cnt <= '0;
                    if (!rx_sync)
                        state <= rx_start;
                end
                rx_start: begin
                    // recheck at mid bit to reject glitches
                    if (half_done) begin
                        baud_cnt <= '0;
                        bit_idx  <= '0;
                        state    <= rx_sync ? rx_idle : rx_data;
                    end
                end
                rx_data: begin
                    if (bit_done) begin
                        shift_reg <= {rx_sync, shift_reg[7:1]};
                        bit_idx   <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                            state <= rx_stop;
                    end
                end
                default: begin
                    if (bit_done) begin
                        if (rx_sync) begin
                            rx_byte  <= shift_reg;
                            rx_valid <= 1'b1;
                        end
                        state <= rx_idle;
                    end
                end
            endcase
        end
    end

endmodule

//--- mmio_uart_tx.sv
`timescale 1ns/1ps

module mmio_uart_tx (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            cmd_start,
    input  logic            write,
    input  mmio_pkg::addr_t offset,
    input  mmio_pkg::word_t wdata,
    output logic            cmd_ready,
    output mmio_pkg::word_t rdata,
    output logic            rdata_valid,
    output logic            uart_tx
);

    typedef enum logic [1:0] {
        tx_idle,
        tx_start,
        tx_data,
        tx_stop
    } uart_tx_state_e;

    uart_tx_state_e                 state;
    logic [mmio_pkg::baud_bits-1:0] baud_cnt;
    logic [2:0]                     bit_idx;
    mmio_pkg::byte_t                shift_reg;
    mmio_pkg::byte_t                sent_cnt;
    logic                           bit_done;

    assign bit_done  = int'(baud_cnt) == mmio_pkg::clks_per_bit - 1;
    // busy for the whole frame, which stalls the requester
    assign cmd_ready = (state == tx_idle);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= tx_idle;
            baud_cnt    <= '0;
            bit_idx     <= '0;
            sent_cnt    <= '0;
            uart_tx     <= 1'b1;
            rdata_valid <= 1'b0;
        end else begin
            rdata_valid <= 1'b0;
            baud_cnt    <= bit_done ? '0 : baud_cnt + 1'b1;
            case (state)
                tx_idle: begin
                    baud_cnt <= '0;
                    if (cmd_start && !write) begin
                        rdata       <= {24'h0, sent_cnt};
                        rdata_valid <= 1'b1;
                    end else if (cmd_start && offset[3:2] == 2'b00) begin
                        // only the data register at offset 0 sends
                        shift_reg <= wdata[7:0];
                        uart_tx   <= 1'b0;
                        state     <= tx_start;
                    end
                end
                tx_start: begin
                    if (bit_done) begin
                        uart_tx   <= shift_reg[0];
                        shift_reg <= {1'b0, shift_reg[7:1]};
                        bit_idx   <= '0;
                        state     <= tx_data;
                    end
                end
                tx_data: begin
                    if (bit_done) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            uart_tx <= 1'b1;
                            state   <= tx_stop;
                        end else begin
                            uart_tx   <= shift_reg[0];
                            shift_reg <= {1'b0, shift_reg[7:1]};
                        end
                    end
                end
                default: begin
                    if (bit_done) begin
                        sent_cnt <= sent_cnt + 1'b1;
                        state    <= tx_idle;
                    end
                end
            endcase
        end
    end

endmodule

//--- data_memory.sv
`timescale 1ns/1ps

module data_memory (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            cmd_start,
    input  logic            write,
    input  mmio_pkg::addr_t addr,
    input  mmio_pkg::word_t wdata,
    output logic            cmd_ready,
    output mmio_pkg::word_t rdata,
    output logic            rdata_valid
);

    mmio_pkg::word_t                    mem [mmio_pkg::mem_words];
    logic [mmio_pkg::mem_addr_bits-1:0] word_idx;

    // word index, upper bits ignored so the array wraps
    assign word_idx  = addr[mmio_pkg::mem_addr_bits+1:2];
    assign cmd_ready = 1'b1;

    always_ff @(posedge clk) begin
        if (cmd_start && write)
            mem[word_idx] <= wdata;
        if (cmd_start && !write)
            rdata <= mem[word_idx];
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            rdata_valid <= 1'b0;
        else
            rdata_valid <= cmd_start && !write;
    end

endmodule

//--- mem_map_ctrl.sv
`timescale 1ns/1ps

module mem_map_ctrl (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            cmd_start,
    input  logic            write,
    input  mmio_pkg::addr_t addr,
    input  mmio_pkg::word_t wdata,
    output logic            cmd_ready,
    output mmio_pkg::word_t rdata,
    output logic            rdata_valid,

    output logic            mem_start,
    output logic            mem_write,
    output mmio_pkg::addr_t mem_addr,
    output mmio_pkg::word_t mem_wdata,
    input  logic            mem_ready,
    input  mmio_pkg::word_t mem_rdata,
    input  logic            mem_rdata_valid,

    output logic            uart_tx_start,
    output logic            uart_tx_write,
    output mmio_pkg::addr_t uart_tx_offset,
    output mmio_pkg::word_t uart_tx_wdata,
    input  logic            uart_tx_ready,
    input  mmio_pkg::word_t uart_tx_rdata,
    input  logic            uart_tx_rdata_valid,

    output logic            uart_rx_start,
    output logic            uart_rx_write,
    output mmio_pkg::addr_t uart_rx_offset,
    output mmio_pkg::word_t uart_rx_wdata,
    input  logic            uart_rx_ready,
    input  mmio_pkg::word_t uart_rx_rdata,
    input  logic            uart_rx_rdata_valid,

    output logic            mtime_start,
    output logic            mtime_write,
    output mmio_pkg::addr_t mtime_offset,
    output mmio_pkg::word_t mtime_wdata,
    input  logic            mtime_ready,
    input  mmio_pkg::word_t mtime_rdata,
    input  logic            mtime_rdata_valid
);

    mmio_pkg::target_e live_tgt;
    mmio_pkg::target_e saved_tgt;
    logic              accept;

    function automatic logic in_window(mmio_pkg::addr_t a, mmio_pkg::addr_t base);
        return (a >= base) && (a < base + mmio_pkg::periph_span);
    endfunction

    // anything outside the peripheral windows is memory
    always_comb begin
        if (in_window(addr, mmio_pkg::uart_tx_base))
            live_tgt = mmio_pkg::tgt_uart_tx;
        else if (in_window(addr, mmio_pkg::uart_rx_base))
            live_tgt = mmio_pkg::tgt_uart_rx;
        else if (in_window(addr, mmio_pkg::mtime_base))
            live_tgt = mmio_pkg::tgt_mtime;
        else
            live_tgt = mmio_pkg::tgt_mem;
    end

    // start only reaches a target once the previous command has finished
    assign accept = cmd_start && cmd_ready;

    assign mem_start     = accept && (live_tgt == mmio_pkg::tgt_mem);
    assign uart_tx_start = accept && (live_tgt == mmio_pkg::tgt_uart_tx);
    assign uart_rx_start = accept && (live_tgt == mmio_pkg::tgt_uart_rx);
    assign mtime_start   = accept && (live_tgt == mmio_pkg::tgt_mtime);

    assign mem_write     = write && (live_tgt == mmio_pkg::tgt_mem);
    assign uart_tx_write = write && (live_tgt == mmio_pkg::tgt_uart_tx);
    assign uart_rx_write = write && (live_tgt == mmio_pkg::tgt_uart_rx);
    assign mtime_write   = write && (live_tgt == mmio_pkg::tgt_mtime);

    assign mem_addr       = addr;
    assign uart_tx_offset = addr - mmio_pkg::uart_tx_base;
    assign uart_rx_offset = addr - mmio_pkg::uart_rx_base;
    assign mtime_offset   = addr - mmio_pkg::mtime_base;

    assign mem_wdata     = wdata;
    assign uart_tx_wdata = wdata;
    assign uart_rx_wdata = wdata;
    assign mtime_wdata   = wdata;

    always_ff @(posedge clk) begin
        if (!rst_n)
            saved_tgt <= mmio_pkg::tgt_mem;
        else if (accept)
            saved_tgt <= live_tgt;
    end

    // response path follows the target that took the last command
    always_comb begin
        case (saved_tgt)
            mmio_pkg::tgt_uart_tx: begin
                cmd_ready   = uart_tx_ready;
                rdata       = uart_tx_rdata;
                rdata_valid = uart_tx_rdata_valid;
            end
            mmio_pkg::tgt_uart_rx: begin
                cmd_ready   = uart_rx_ready;
                rdata       = uart_rx_rdata;
                rdata_valid = uart_rx_rdata_valid;
            end
            mmio_pkg::tgt_mtime: begin
                cmd_ready   = mtime_ready;
                rdata       = mtime_rdata;
                rdata_valid = mtime_rdata_valid;
            end
            default: begin
                cmd_ready   = mem_ready;
                rdata       = mem_rdata;
                rdata_valid = mem_rdata_valid;
            end
        endcase
    end

endmodule

//--- mmio_pkg.sv
package mmio_pkg;

    // data path widths
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [7:0]  byte_t;
    typedef logic [63:0] mtime_t;

    // target chosen by the address decoder
    typedef enum logic [1:0] {
        tgt_mem,
        tgt_uart_tx,
        tgt_uart_rx,
        tgt_mtime
    } target_e;

    // data memory size in words
    localparam int mem_words     = 1024;
    localparam int mem_addr_bits = $clog2(mem_words);

    // peripheral windows, 16 bytes each
    localparam addr_t uart_tx_base = 32'h0000_1000;
    localparam addr_t uart_rx_base = 32'h0000_1010;
    localparam addr_t mtime_base   = 32'h0000_1020;
    localparam addr_t periph_span  = 32'd16;

    // serial bit period in clocks
    localparam int clks_per_bit = 16;
    localparam int baud_bits    = $clog2(clks_per_bit);

endpackage
